// File: hw/flit_serializer.sv
// Combinational cut-through serializer that needs word_beat held stable until word_ready
module flit_serializer (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         word_valid,
  output logic                         word_ready,
  input  serdes_types_pkg::push_beat_t word_beat,
  output logic                         flit_valid,
  input  logic                         flit_ready,
  output serdes_types_pkg::pop_beat_t  flit_beat
);

  import serdes_cfg_pkg::*;
  import serdes_types_pkg::*;

  logic                       word_valid_q;
  logic                       word_done_q;
  logic                       restart;
  logic                       flit_xfer;
  logic                       word_done;
  slice_cnt_t                 slice_cnt_q;
  slice_cnt_t                 flit_idx;
  slice_cnt_t                 slice_sel;
  slice_cnt_t                 eff_dont_care;
  slice_cnt_t                 idx_plus_dc;
  lane_flit_t [SER_RATIO-1:0] slices;

  assign flit_xfer = flit_valid && flit_ready;

  // ----------------------------------------------------------
  // Slice counter
  // ----------------------------------------------------------

  // Previous cycle's word handshake, used to spot the start of a new word
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      word_valid_q <= 1'b0;
      word_done_q  <= 1'b0;
    end else begin
      word_valid_q <= word_valid;
      word_done_q  <= word_valid && word_ready;
    end
  end

  // A word is new if nothing was presented last cycle or the previous word just finished
  // In that cycle index 0 is used directly, so there is no bubble between words
  assign restart  = word_valid && (!word_valid_q || word_done_q);
  assign flit_idx = restart ? '0 : slice_cnt_q;

  // The counter also loads on a stalled restart so a stale value never comes back
  // A full word wraps the counter back to 0 by itself
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slice_cnt_q <= '0;
    end else if (restart || flit_xfer) begin
      slice_cnt_q <= flit_idx + slice_cnt_t'(flit_xfer);
    end
  end

  // ----------------------------------------------------------
  // Slice select
  // ----------------------------------------------------------

  // View the word as an array of flits, slice 0 being the least significant
  assign slices = word_beat.data;

  // MSB-first order walks the array from the top down
  assign slice_sel = MSB_FIRST ? slice_cnt_t'(SER_RATIO - 1 - flit_idx) : flit_idx;

  // ----------------------------------------------------------
  // Early termination and flit outputs
  // ----------------------------------------------------------

  // Only a last word may drop its trailing don't-care slices
  assign eff_dont_care = word_beat.last ? word_beat.dont_care_count : '0;
  assign idx_plus_dc   = flit_idx + eff_dont_care;

  // True on the final flit this word produces
  assign word_done = (idx_plus_dc == slice_cnt_t'(SER_RATIO - 1));

  assign flit_valid = word_valid;

  always_comb begin
    flit_beat.data = slices[slice_sel];
    // Packet end is flagged only on the final kept slice of a last word
    flit_beat.last = word_beat.last && word_done;
    flit_beat.meta = word_beat.meta;
  end

  // Release the word once its final flit is taken downstream
  assign word_ready = flit_ready && word_done;

endmodule : flit_serializer

// File: hw/lane_egress_stage.sv
// Registered output with one skid entry, so flit_ready never depends on out_ready in the same cycle
module lane_egress_stage (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         flit_valid,
  output logic                         flit_ready,
  input  serdes_types_pkg::pop_beat_t  flit_beat,
  output logic                         out_valid,
  input  logic                         out_ready,
  output serdes_types_pkg::lane_beat_t out_beat
);

  import serdes_types_pkg::*;

  lane_beat_t in_lane;
  lane_beat_t skid_beat_q;
  logic       skid_valid_q;
  logic       flit_xfer;
  logic       out_free;

  // ----------------------------------------------------------
  // Parity and handshakes
  // ----------------------------------------------------------

  // Even parity makes the XOR over data plus parity come out zero
  always_comb begin
    in_lane.beat   = flit_beat;
    in_lane.parity = ^flit_beat.data;
  end

  // Accept new flits only while the skid entry is free
  assign flit_ready = !skid_valid_q;
  assign flit_xfer  = flit_valid && flit_ready;

  // Output slot can take a new flit when empty or being drained this cycle
  assign out_free = !out_valid || out_ready;

  // ----------------------------------------------------------
  // Slot control
  // ----------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid    <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      // The skid entry has priority, which keeps the flit order intact
      if (out_free) begin
        out_valid <= skid_valid_q || flit_xfer;
      end
      // A flit that arrives while the output slot is stuck parks in the skid
      if (skid_valid_q && out_free) begin
        skid_valid_q <= 1'b0;
      end else if (flit_xfer && !out_free) begin
        skid_valid_q <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Payload
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (out_free) begin
      out_beat <= skid_valid_q ? skid_beat_q : in_lane;
    end
    if (flit_xfer && !out_free) begin
      skid_beat_q <= in_lane;
    end
  end

endmodule : lane_egress_stage

// File: hw/serdes_cfg_pkg.sv
// Fixed 32-to-8 configuration with MSB-first order only, so PUSH_WIDTH must stay a multiple of POP_WIDTH
package serdes_cfg_pkg;

  // ----------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------

  // Width of one packet word on the push side
  localparam int PUSH_WIDTH = 32;

  // Width of one flit on the narrow lane
  localparam int POP_WIDTH = 8;

  // Sideband metadata that rides along with every flit unchanged
  localparam int META_WIDTH = 3;

  // ----------------------------------------------------------
  // Serialization ratio and order
  // ----------------------------------------------------------

  // Number of flits carved out of one full word
  localparam int SER_RATIO = PUSH_WIDTH / POP_WIDTH;

  // Enough bits to index a slice or count the don't-care slices
  localparam int SLICE_ID_WIDTH = $clog2(SER_RATIO);

  // The most significant slice leaves first when this is set
  // The don't-care slices of a last word are then the low ones
  localparam bit MSB_FIRST = 1'b1;

endpackage : serdes_cfg_pkg

// File: hw/serdes_types_pkg.sv
// Beat layouts are packed MSB-first in declaration order and assume the widths of serdes_cfg_pkg
package serdes_types_pkg;

  import serdes_cfg_pkg::*;

  // ----------------------------------------------------------
  // Plain vectors with a meaning
  // ----------------------------------------------------------

  typedef logic [PUSH_WIDTH-1:0] push_word_t;
  typedef logic [POP_WIDTH-1:0] lane_flit_t;
  typedef logic [META_WIDTH-1:0] meta_t;

  // Slice index inside a word, also used for the don't-care count
  typedef logic [SLICE_ID_WIDTH-1:0] slice_cnt_t;

  // ----------------------------------------------------------
  // Beats on the three links
  // ----------------------------------------------------------

  // One packet word as it enters the subsystem
  // The don't-care count only matters when last is set
  typedef struct packed {
    push_word_t data;
    logic       last;
    slice_cnt_t dont_care_count;
    meta_t      meta;
  } push_beat_t;

  // One flit leaving the serializer
  typedef struct packed {
    lane_flit_t data;
    logic       last;
    meta_t      meta;
  } pop_beat_t;

  // Flit on the output lane with even parity over its data bits
  typedef struct packed {
    pop_beat_t beat;
    logic      parity;
  } lane_beat_t;

  // Occupancy of the two-entry ingress buffer
  typedef enum logic [1:0] {
    buf_empty,
    buf_one,
    buf_two
  } buf_state_t;

endpackage : serdes_types_pkg

// File: hw/wide_to_narrow_serdes.sv
// Top level with two cycles from word handshake to first flit when out_ready stays high
module wide_to_narrow_serdes (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  serdes_types_pkg::push_beat_t in_beat,
  output logic                         out_valid,
  input  logic                         out_ready,
  output serdes_types_pkg::lane_beat_t out_beat
);

  import serdes_types_pkg::*;

  // ----------------------------------------------------------
  // Internal links
  // ----------------------------------------------------------

  // Buffered word presented to the serializer
  logic       word_valid;
  logic       word_ready;
  push_beat_t word_beat;

  // Narrow flits toward the egress stage
  logic       flit_valid;
  logic       flit_ready;
  pop_beat_t  flit_beat;

  // Holds words stable for the whole time they are being sliced
  word_ingress_buffer ingress_buf_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_beat    (in_beat),
    .word_valid (word_valid),
    .word_ready (word_ready),
    .word_beat  (word_beat)
  );

  // Zero-cycle cut-through from buffered word to flit
  flit_serializer serializer_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .word_valid (word_valid),
    .word_ready (word_ready),
    .word_beat  (word_beat),
    .flit_valid (flit_valid),
    .flit_ready (flit_ready),
    .flit_beat  (flit_beat)
  );

  // Adds parity and breaks the ready path toward the serializer
  lane_egress_stage egress_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .flit_valid (flit_valid),
    .flit_ready (flit_ready),
    .flit_beat  (flit_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_beat   (out_beat)
  );

endmodule : wide_to_narrow_serdes

// File: hw/word_ingress_buffer.sv
// Two-entry buffer with one cycle of latency where in_ready depends only on occupancy
module word_ingress_buffer (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  serdes_types_pkg::push_beat_t in_beat,
  output logic                         word_valid,
  input  logic                         word_ready,
  output serdes_types_pkg::push_beat_t word_beat
);

  import serdes_types_pkg::*;

  // Storage is two words deep, so one-bit pointers wrap on their own
  push_beat_t mem [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  buf_state_t state_q;
  buf_state_t state_d;
  logic       push;
  logic       pop;

  // ----------------------------------------------------------
  // Handshakes
  // ----------------------------------------------------------

  // Room for another word unless both entries are taken
  assign in_ready = (state_q != buf_two);

  // The head word is presented straight from storage
  // It stays put until the serializer releases it
  assign word_valid = (state_q != buf_empty);
  assign word_beat  = mem[rd_ptr_q];

  assign push = in_valid && in_ready;
  assign pop  = word_valid && word_ready;

  // ----------------------------------------------------------
  // Occupancy FSM
  // ----------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      buf_empty: begin
        if (push) begin
          state_d = buf_one;
        end
      end
      buf_one: begin
        // A push and a pop in the same cycle leave one word stored
        if (push && !pop) begin
          state_d = buf_two;
        end else if (pop && !push) begin
          state_d = buf_empty;
        end
      end
      buf_two: begin
        // in_ready is low here, so only a pop can happen
        if (pop) begin
          state_d = buf_one;
        end
      end
      default: state_d = buf_empty;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= buf_empty;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
    end
  end

  // ----------------------------------------------------------
  // Word storage
  // ----------------------------------------------------------

  // Written only on an accepted push, never while the entry is read
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= in_beat;
    end
  end

endmodule : word_ingress_buffer

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# The exit status of the simulation binary is the pass or fail result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --top-module serdes_tb \
  -f serdes.f \
  --Mdir obj_dir \
  -o serdes_sim

./obj_dir/serdes_sim

// File: serdes.f
hw/serdes_cfg_pkg.sv
hw/serdes_types_pkg.sv
hw/word_ingress_buffer.sv
hw/flit_serializer.sv
hw/lane_egress_stage.sv
hw/wide_to_narrow_serdes.sv
tests/serdes_tb.sv

// File: tests/serdes_stim.txt
// First data line: word count and section-one word count, both hex
// Then one word per line: data, last, don't-care count, meta (all hex)
22 0e
// Section one, out_ready held high
11223344 0 0 1
55667788 1 0 2
a1b2c3d4 1 1 3
deadbeef 1 2 4
cafef00d 1 3 5
0f1e2d3c 0 2 6
4b5a6978 1 3 7
87969faa 1 3 0
01020304 0 0 1
05060708 0 0 1
090a0b0c 1 1 1
ffffffff 1 0 7
00000000 1 2 0
13579bdf 0 0 3
// Section two, random out_ready
2468ace0 1 0 3
80402010 0 0 5
08040201 1 1 5
7e7e7e7e 1 3 6
c3a5965a 0 3 4
3c3c0ff0 1 2 4
9abcdef0 0 0 1
12345678 0 0 1
0badc0de 0 0 1
feedface 1 0 1
6b1d2e9f 1 1 3
a5a5a5a5 1 3 2
5a5a5a5a 1 2 2
00ff00ff 0 1 0
ff00ff00 1 1 0
e1d2c3b4 1 2 7
76543210 0 0 6
fedcba98 1 0 6
3f2e1d0c 1 3 3
91a2b3c4 1 1 5

// File: tests/serdes_tb.sv
// Runs from the project root so tests/serdes_stim.txt resolves, and assumes the fixed 32-to-8 MSB-first ratio
module serdes_tb;

  import serdes_cfg_pkg::*;
  import serdes_types_pkg::*;

  localparam int MAX_WORDS     = 64;
  localparam int STIM_DEPTH    = 2 + 4 * MAX_WORDS;
  localparam int READY_TIMEOUT = 200;
  localparam int DONE_TIMEOUT  = 5000;
  localparam int DRIVE_DELAY   = 2;
  localparam int RNG_SEED      = 73302;

  logic       clk = 1'b0;
  logic       arst_n;
  logic       in_valid;
  logic       in_ready;
  push_beat_t in_beat;
  logic       out_valid;
  logic       out_ready;
  lane_beat_t out_beat;

  // Raw stimulus, two count tokens followed by four tokens per word
  logic [PUSH_WIDTH-1:0] stim_mem [STIM_DEPTH];
  int                    word_cnt;
  int                    sec1_words;
  int                    sec1_flits  = 0;
  int                    total_flits = 0;
  int                    checked_cnt = 0;

  // Expected flits in transfer order, each with a name for error lines
  pop_beat_t exp_q [$];
  string     name_q [$];

  wide_to_narrow_serdes dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  always #10 clk = ~clk;

  // ----------------------------------------------------------
  // Failure reporting and compare tasks
  // ----------------------------------------------------------

  task automatic halt_on_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run aborted at first failure");
  endtask

  task automatic check_flit(input string name, input lane_flit_t exp, input lane_flit_t act);
    if (act !== exp) begin
      $display("** Error: %s data expected %h actual %h", name, exp, act);
      halt_on_failure();
    end
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s last expected %b actual %b", name, exp, act);
      halt_on_failure();
    end
  endtask

  task automatic check_meta(input string name, input meta_t exp, input meta_t act);
    if (act !== exp) begin
      $display("** Error: %s meta expected %h actual %h", name, exp, act);
      halt_on_failure();
    end
  endtask

  task automatic check_parity(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s parity expected %b actual %b", name, exp, act);
      halt_on_failure();
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus decoding and flit prediction
  // ----------------------------------------------------------

  function automatic push_beat_t beat_from_stim(input int idx);
    int         base;
    push_beat_t beat;
    base                 = 2 + 4 * idx;
    beat.data            = stim_mem[base];
    beat.last            = stim_mem[base + 1][0];
    beat.dont_care_count = stim_mem[base + 2][SLICE_ID_WIDTH-1:0];
    beat.meta            = stim_mem[base + 3][META_WIDTH-1:0];
    return beat;
  endfunction

  // Only a last word loses its don't-care tail
  function automatic int flits_per_word(input push_beat_t beat);
    int n;
    n = SER_RATIO;
    if (beat.last) begin
      n = SER_RATIO - int'(beat.dont_care_count);
    end
    return n;
  endfunction

  // Slices are taken from the top of the word downward
  task automatic predict_word(input push_beat_t beat, input int word_idx);
    int        n;
    string     test;
    pop_beat_t flit;
    n    = flits_per_word(beat);
    test = (word_idx < sec1_words) ? "back_to_back" : "random_ready";
    for (int s = 0; s < n; s++) begin
      flit.data = beat.data[PUSH_WIDTH-1-s*POP_WIDTH -: POP_WIDTH];
      flit.last = beat.last && (s == n - 1);
      flit.meta = beat.meta;
      exp_q.push_back(flit);
      name_q.push_back($sformatf("%s word %0d flit %0d", test, word_idx, s));
    end
  endtask

  // Called just after a rising edge, returns just after the edge that took the word
  task automatic push_word(input push_beat_t beat, input int word_idx);
    int waited;
    waited   = 0;
    in_valid = 1'b1;
    in_beat  = beat;
    // in_ready follows buffer occupancy only, so it is settled here for the coming edge
    while (!in_ready) begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
      if (waited > READY_TIMEOUT) begin
        $display("Timeout: in_ready stayed low for word %0d", word_idx);
        halt_on_failure();
      end
    end
    predict_word(beat, word_idx);
    @(posedge clk);
    #DRIVE_DELAY;
    in_valid = 1'b0;
  endtask

  // ----------------------------------------------------------
  // Output ready, held high first and then random
  // ----------------------------------------------------------

  initial begin : ready_driver
    logic [31:0] rnd;
    rnd       = $urandom(RNG_SEED);
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (sec1_flits == 0 || checked_cnt < sec1_flits) begin
        out_ready = 1'b1;
      end else begin
        rnd       = $urandom();
        out_ready = rnd[0];
      end
    end
  end

  // ----------------------------------------------------------
  // Monitor, sampled at the falling edge where outputs are settled
  // ----------------------------------------------------------

  always @(negedge clk) begin : monitor
    pop_beat_t exp_flit;
    string     name;
    if (arst_n) begin
      // Back-to-back words with out_ready high must not leave a gap
      if (checked_cnt > 0 && checked_cnt < sec1_flits && !out_valid) begin
        $display("Bubble: out_valid fell low after %0d flits with out_ready high", checked_cnt);
        halt_on_failure();
      end
      if (out_valid && exp_q.size() == 0) begin
        $display("Extra flit: out_valid is high while no flit is expected");
        halt_on_failure();
      end
      if (out_valid && out_ready) begin
        exp_flit = exp_q.pop_front();
        name     = name_q.pop_front();
        check_flit(name, exp_flit.data, out_beat.beat.data);
        check_last(name, exp_flit.last, out_beat.beat.last);
        check_meta(name, exp_flit.meta, out_beat.beat.meta);
        check_parity(name, ^exp_flit.data, out_beat.parity);
        checked_cnt++;
      end
    end
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin : main_seq
    push_beat_t beat;
    int         waited;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    in_beat  = '0;
    repeat (8) @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b1;

    $readmemh("tests/serdes_stim.txt", stim_mem);
    word_cnt   = int'(stim_mem[0]);
    sec1_words = int'(stim_mem[1]);
    if (word_cnt < 1 || word_cnt > MAX_WORDS || sec1_words > word_cnt) begin
      $display("Bad stimulus file: %0d words with %0d in section one", word_cnt, sec1_words);
      halt_on_failure();
    end
    for (int i = 0; i < word_cnt; i++) begin
      beat        = beat_from_stim(i);
      total_flits += flits_per_word(beat);
      if (i < sec1_words) begin
        sec1_flits += flits_per_word(beat);
      end
    end

    @(posedge clk);
    #DRIVE_DELAY;
    for (int i = 0; i < word_cnt; i++) begin
      push_word(beat_from_stim(i), i);
    end

    waited = 0;
    while (checked_cnt < total_flits) begin
      @(posedge clk);
      waited++;
      if (waited > DONE_TIMEOUT) begin
        $display("Timeout: %0d of %0d flits arrived", checked_cnt, total_flits);
        halt_on_failure();
      end
    end

    // Let any duplicate flit show up at the monitor
    repeat (20) @(posedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule : serdes_tb
